// File: source/seq_pkg.sv
`default_nettype none

package seq_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Number of instruction IDs that can be in flight at the same time
  localparam int unsigned NUM_VINSN = 8;
  // Architectural vector registers
  localparam int unsigned NUM_VREGS = 32;
  // ALU, multiplier, load unit and store unit
  localparam int unsigned NUM_UNITS = 4;
  // Counter width, enough to hold the deepest unit queue
  localparam int unsigned CNT_W     = 3;

  typedef logic [$clog2(NUM_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NUM_VREGS)-1:0] vreg_t;
  // One bit per instruction ID
  typedef logic [NUM_VINSN-1:0]         vinsn_vec_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_VADD_VV = 3'd0,
    OP_VADD_VX = 3'd1,
    OP_VMV_VI  = 3'd2,
    OP_VMUL_VV = 3'd3,
    OP_VMUL_VX = 3'd4,
    OP_VLE     = 3'd5,
    OP_VSE     = 3'd6
  } op_e;

  // The order here also indexes UNIT_DEPTH and the done rows
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  // Queue depth of each unit, in unit_e order
  localparam logic [CNT_W-1:0] UNIT_DEPTH [NUM_UNITS] = '{3'd4, 3'd4, 3'd2, 3'd2};

  // Decoder result: the target unit, also one-hot, and the register usage flags
  typedef struct packed {
    unit_e                unit;
    logic [NUM_UNITS-1:0] unit_oh;
    logic                 use_vd;
    logic                 use_vs1;
    logic                 use_vs2;
  } dec_t;

  // Request sent to the processing elements
  typedef struct packed {
    vid_t       id;
    op_e        op;
    unit_e      unit;
    vreg_t      vd;
    vreg_t      vs1;
    vreg_t      vs2;
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vd;
  } pe_req_t;

endpackage

`default_nettype wire

// File: source/hazard_if.sv
`default_nettype none

// Link between the issue controller and the hazard tracker
interface hazard_if;
  import seq_pkg::*;

  // Issue side: acceptance strobe, the ID being given out and the running set
  logic       fire;
  vid_t       id;
  vinsn_vec_t running;

  // Tracker side: hazard vectors for the request on the dispatcher port
  vinsn_vec_t hazard_vs1;
  vinsn_vec_t hazard_vs2;
  vinsn_vec_t hazard_vd;

  modport issuer (
    output fire, id, running,
    input  hazard_vs1, hazard_vs2, hazard_vd
  );

  modport tracker (
    input  fire, id, running,
    output hazard_vs1, hazard_vs2, hazard_vd
  );

endinterface

`default_nettype wire

// File: source/op_decoder.sv
`default_nettype none

module op_decoder (
  input  seq_pkg::op_e  op_i,
  output seq_pkg::dec_t dec_o
);
  import seq_pkg::*;

  unit_e unit;
  logic  use_vd;
  logic  use_vs1;
  logic  use_vs2;

  // Each operation maps to exactly one unit and a fixed set of operands
  always_comb begin
    unit    = UNIT_ALU;
    use_vd  = 1'b0;
    use_vs1 = 1'b0;
    use_vs2 = 1'b0;
    unique case (op_i)
      OP_VADD_VV: begin
        use_vd  = 1'b1;
        use_vs1 = 1'b1;
        use_vs2 = 1'b1;
      end
      // The scalar operand replaces vs1
      OP_VADD_VX: begin
        use_vd  = 1'b1;
        use_vs2 = 1'b1;
      end
      // Immediate move reads nothing from the register file
      OP_VMV_VI: use_vd = 1'b1;
      OP_VMUL_VV: begin
        unit    = UNIT_MUL;
        use_vd  = 1'b1;
        use_vs1 = 1'b1;
        use_vs2 = 1'b1;
      end
      OP_VMUL_VX: begin
        unit    = UNIT_MUL;
        use_vd  = 1'b1;
        use_vs2 = 1'b1;
      end
      OP_VLE: begin
        unit   = UNIT_LOAD;
        use_vd = 1'b1;
      end
      // Store data comes from the vs1 field
      OP_VSE: begin
        unit    = UNIT_STORE;
        use_vs1 = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    dec_o               = '0;
    dec_o.unit          = unit;
    dec_o.unit_oh[unit] = 1'b1;
    dec_o.use_vd        = use_vd;
    dec_o.use_vs1       = use_vs1;
    dec_o.use_vs2       = use_vs2;
  end

endmodule

`default_nettype wire

// File: source/unit_queue_cnt.sv
`default_nettype none

module unit_queue_cnt #(
  parameter seq_pkg::unit_e UNIT = seq_pkg::UNIT_ALU
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  seq_pkg::dec_t       dec_i,
  input  logic                fire_i,
  input  seq_pkg::vinsn_vec_t done_i,
  output logic                issue_ok_o
);
  import seq_pkg::*;

  logic [CNT_W-1:0] count_q;
  logic             targeted;
  logic             cnt_up;
  logic             cnt_down;

  // The current request is aimed at this unit
  assign targeted = dec_i.unit_oh[UNIT];

  // One issue and one completion in the same cycle cancel out
  assign cnt_up   = fire_i && targeted;
  assign cnt_down = |done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (cnt_up && !cnt_down) begin
      count_q <= count_q + CNT_W'(1);
    end else if (cnt_down && !cnt_up && count_q != '0) begin
      count_q <= count_q - CNT_W'(1);
    end
  end

  // Other units' instructions never wait on this queue
  assign issue_ok_o = !targeted || (count_q < UNIT_DEPTH[UNIT]);

endmodule

`default_nettype wire

// File: source/hazard_tracker.sv
`default_nettype none

module hazard_tracker (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  seq_pkg::vreg_t                              ara_req_vd_i,
  input  seq_pkg::vreg_t                              ara_req_vs1_i,
  input  seq_pkg::vreg_t                              ara_req_vs2_i,
  input  seq_pkg::dec_t                               dec_i,
  hazard_if.tracker                                   hz,
  output seq_pkg::vinsn_vec_t [seq_pkg::NUM_VINSN-1:0] global_hazard_table_o
);
  import seq_pkg::*;

  // Owner of a register access, valid only while that ID is still running
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [NUM_VREGS-1:0] write_list_d, write_list_q;
  vreg_access_t [NUM_VREGS-1:0] read_list_d, read_list_q;

  // Row N holds the IDs that instruction N depends on
  vinsn_vec_t [NUM_VINSN-1:0] table_d, table_q;

  vinsn_vec_t hazard_vs1;
  vinsn_vec_t hazard_vs2;
  vinsn_vec_t hazard_vd;

  // An entry stops counting the cycle its owner is no longer running
  function automatic logic live(vreg_access_t entry, vinsn_vec_t running);
    return entry.valid && running[entry.vid];
  endfunction

  //////////////////////////////
  // Hazard vectors
  //////////////////////////////

  always_comb begin
    hazard_vs1 = '0;
    hazard_vs2 = '0;
    hazard_vd  = '0;
    // RAW on the sources
    if (dec_i.use_vs1 && live(write_list_q[ara_req_vs1_i], hz.running)) begin
      hazard_vs1[write_list_q[ara_req_vs1_i].vid] = 1'b1;
    end
    if (dec_i.use_vs2 && live(write_list_q[ara_req_vs2_i], hz.running)) begin
      hazard_vs2[write_list_q[ara_req_vs2_i].vid] = 1'b1;
    end
    if (dec_i.use_vd) begin
      // WAR against the last reader of vd
      if (live(read_list_q[ara_req_vd_i], hz.running)) begin
        hazard_vd[read_list_q[ara_req_vd_i].vid] = 1'b1;
      end
      // WAW against the last writer of vd
      if (live(write_list_q[ara_req_vd_i], hz.running)) begin
        hazard_vd[write_list_q[ara_req_vd_i].vid] = 1'b1;
      end
    end
  end

  assign hz.hazard_vs1 = hazard_vs1;
  assign hz.hazard_vs2 = hazard_vs2;
  assign hz.hazard_vd  = hazard_vd;

  //////////////////////////////
  // Lists and table update
  //////////////////////////////

  always_comb begin
    // Drop entries whose owner has finished, so a reused ID never aliases
    for (int v = 0; v < NUM_VREGS; v++) begin
      write_list_d[v]       = write_list_q[v];
      write_list_d[v].valid = live(write_list_q[v], hz.running);
      read_list_d[v]        = read_list_q[v];
      read_list_d[v].valid  = live(read_list_q[v], hz.running);
    end
    // Columns of finished instructions are cleared
    for (int i = 0; i < NUM_VINSN; i++) begin
      table_d[i] = table_q[i] & hz.running;
    end
    if (hz.fire) begin
      if (dec_i.use_vd) begin
        write_list_d[ara_req_vd_i] = '{vid: hz.id, valid: 1'b1};
      end
      if (dec_i.use_vs1) begin
        read_list_d[ara_req_vs1_i] = '{vid: hz.id, valid: 1'b1};
      end
      if (dec_i.use_vs2) begin
        read_list_d[ara_req_vs2_i] = '{vid: hz.id, valid: 1'b1};
      end
      table_d[hz.id] = hazard_vs1 | hazard_vs2 | hazard_vd;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_list_q <= '0;
      read_list_q  <= '0;
      table_q      <= '0;
    end else begin
      write_list_q <= write_list_d;
      read_list_q  <= read_list_d;
      table_q      <= table_d;
    end
  end

  assign global_hazard_table_o = table_q;

endmodule

`default_nettype wire

// File: source/issue_ctrl.sv
`default_nettype none

module issue_ctrl (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Dispatcher request
  input  logic                                        ara_req_valid_i,
  input  seq_pkg::op_e                                ara_req_op_i,
  input  seq_pkg::vreg_t                              ara_req_vd_i,
  input  seq_pkg::vreg_t                              ara_req_vs1_i,
  input  seq_pkg::vreg_t                              ara_req_vs2_i,
  output logic                                        ara_req_ready_o,
  // Decode of the current request
  input  seq_pkg::dec_t                               dec_i,
  // Unit counters
  input  logic [seq_pkg::NUM_UNITS-1:0]               issue_ok_i,
  output logic                                        fire_o,
  // Completion, one row per unit
  input  seq_pkg::vinsn_vec_t [seq_pkg::NUM_UNITS-1:0] unit_done_i,
  hazard_if.issuer                                    hz,
  // Processing elements
  output seq_pkg::pe_req_t                            pe_req_o,
  output logic                                        pe_req_valid_o,
  output logic                                        idle_o
);
  import seq_pkg::*;

  // Running table, a set bit means that ID is busy on that unit
  vinsn_vec_t [NUM_UNITS-1:0] running_d, running_q;
  vinsn_vec_t                 running_any;

  vid_t free_id;
  logic id_free;
  logic no_src;
  logic any_hazard;
  logic stall;

  //////////////////////////////
  // ID allocation
  //////////////////////////////

  always_comb begin
    running_any = '0;
    for (int u = 0; u < NUM_UNITS; u++) begin
      running_any |= running_q[u];
    end
  end

  // Scan downwards so the lowest free ID wins
  always_comb begin
    free_id = '0;
    for (int i = NUM_VINSN - 1; i >= 0; i--) begin
      if (!running_any[i]) begin
        free_id = vid_t'(i);
      end
    end
  end

  assign id_free = !(&running_any);

  //////////////////////////////
  // Ready and stall
  //////////////////////////////

  // Instructions without register sources cannot be chained behind a hazard
  assign no_src     = !dec_i.use_vs1 && !dec_i.use_vs2;
  assign any_hazard = |{hz.hazard_vs1, hz.hazard_vs2, hz.hazard_vd};
  assign stall      = no_src && any_hazard;

  // Only registered state and the request fields feed ready, never valid
  assign ara_req_ready_o = (&issue_ok_i) && id_free && !stall;
  assign fire_o          = ara_req_valid_i && ara_req_ready_o;

  assign hz.fire    = fire_o;
  assign hz.id      = free_id;
  assign hz.running = running_any;

  //////////////////////////////
  // Running table
  //////////////////////////////

  always_comb begin
    for (int u = 0; u < NUM_UNITS; u++) begin
      running_d[u] = running_q[u] & ~unit_done_i[u];
    end
    // A fresh ID is never in the done rows, so setting after clearing is safe
    if (fire_o) begin
      running_d[dec_i.unit][free_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q      <= '0;
      pe_req_valid_o <= 1'b0;
    end else begin
      running_q      <= running_d;
      // One pulse per accepted instruction
      pe_req_valid_o <= fire_o;
    end
  end

  // Request payload, captured together with its hazards
  always_ff @(posedge clk_i) begin
    if (fire_o) begin
      pe_req_o <= '{
        id:         free_id,
        op:         ara_req_op_i,
        unit:       dec_i.unit,
        vd:         ara_req_vd_i,
        vs1:        ara_req_vs1_i,
        vs2:        ara_req_vs2_i,
        hazard_vs1: hz.hazard_vs1,
        hazard_vs2: hz.hazard_vs2,
        hazard_vd:  hz.hazard_vd
      };
    end
  end

  assign idle_o = !(|running_any);

endmodule

`default_nettype wire

// File: source/vector_sequencer.sv
`default_nettype none

module vector_sequencer (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Dispatcher
  input  logic                                        ara_req_valid_i,
  input  seq_pkg::op_e                                ara_req_op_i,
  input  seq_pkg::vreg_t                              ara_req_vd_i,
  input  seq_pkg::vreg_t                              ara_req_vs1_i,
  input  seq_pkg::vreg_t                              ara_req_vs2_i,
  output logic                                        ara_req_ready_o,
  // Completion strobes from the units
  input  seq_pkg::vinsn_vec_t [seq_pkg::NUM_UNITS-1:0] unit_done_i,
  // Processing element request, one port per field
  output logic                                        pe_req_valid_o,
  output seq_pkg::vid_t                               pe_req_id_o,
  output seq_pkg::op_e                                pe_req_op_o,
  output seq_pkg::unit_e                              pe_req_unit_o,
  output seq_pkg::vreg_t                              pe_req_vd_o,
  output seq_pkg::vreg_t                              pe_req_vs1_o,
  output seq_pkg::vreg_t                              pe_req_vs2_o,
  output seq_pkg::vinsn_vec_t                         pe_req_hazard_vs1_o,
  output seq_pkg::vinsn_vec_t                         pe_req_hazard_vs2_o,
  output seq_pkg::vinsn_vec_t                         pe_req_hazard_vd_o,
  // Operand requesters and status
  output seq_pkg::vinsn_vec_t [seq_pkg::NUM_VINSN-1:0] global_hazard_table_o,
  output logic                                        idle_o
);
  import seq_pkg::*;

  dec_t                 dec;
  logic [NUM_UNITS-1:0] issue_ok;
  logic                 fire;
  pe_req_t              pe_req;

  hazard_if hz_if ();

  op_decoder i_op_decoder (
    .op_i  (ara_req_op_i),
    .dec_o (dec)
  );

  // One occupancy counter per functional unit
  for (genvar u = 0; u < NUM_UNITS; u++) begin : gen_unit_cnt
    unit_queue_cnt #(
      .UNIT (unit_e'(u))
    ) i_unit_queue_cnt (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .dec_i      (dec),
      .fire_i     (fire),
      .done_i     (unit_done_i[u]),
      .issue_ok_o (issue_ok[u])
    );
  end

  hazard_tracker i_hazard_tracker (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .ara_req_vd_i          (ara_req_vd_i),
    .ara_req_vs1_i         (ara_req_vs1_i),
    .ara_req_vs2_i         (ara_req_vs2_i),
    .dec_i                 (dec),
    .hz                    (hz_if.tracker),
    .global_hazard_table_o (global_hazard_table_o)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ara_req_valid_i (ara_req_valid_i),
    .ara_req_op_i    (ara_req_op_i),
    .ara_req_vd_i    (ara_req_vd_i),
    .ara_req_vs1_i   (ara_req_vs1_i),
    .ara_req_vs2_i   (ara_req_vs2_i),
    .ara_req_ready_o (ara_req_ready_o),
    .dec_i           (dec),
    .issue_ok_i      (issue_ok),
    .fire_o          (fire),
    .unit_done_i     (unit_done_i),
    .hz              (hz_if.issuer),
    .pe_req_o        (pe_req),
    .pe_req_valid_o  (pe_req_valid_o),
    .idle_o          (idle_o)
  );

  // Flatten the request struct onto the field ports
  assign pe_req_id_o         = pe_req.id;
  assign pe_req_op_o         = pe_req.op;
  assign pe_req_unit_o       = pe_req.unit;
  assign pe_req_vd_o         = pe_req.vd;
  assign pe_req_vs1_o        = pe_req.vs1;
  assign pe_req_vs2_o        = pe_req.vs2;
  assign pe_req_hazard_vs1_o = pe_req.hazard_vs1;
  assign pe_req_hazard_vs2_o = pe_req.hazard_vs2;
  assign pe_req_hazard_vd_o  = pe_req.hazard_vd;

endmodule

`default_nettype wire

// File: verif/sequencer_chk.sv
`default_nettype none

module sequencer_chk (
  input logic                                        clk_i,
  input logic                                        rst_ni,
  input logic                                        ready_i,
  input logic                                        pe_valid_i,
  input seq_pkg::vid_t                               pe_id_i,
  input seq_pkg::vinsn_vec_t [seq_pkg::NUM_UNITS-1:0] running_i,
  input logic                                        idle_i
);
  import seq_pkg::*;

  // IDs busy on any unit
  vinsn_vec_t busy;

  always_comb begin
    busy = '0;
    for (int u = 0; u < NUM_UNITS; u++) begin
      busy |= running_i[u];
    end
  end

  // Each accepted instruction gives a single pulse, so the same ID never repeats
  a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_valid_i && $past(pe_valid_i) |-> pe_id_i != $past(pe_id_i))
    else $error("PE request valid held two cycles with ID %0d", pe_id_i);

  // All eight IDs in use must block the dispatcher
  a_full_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&busy) |-> !ready_i)
    else $error("Ready is high although no instruction ID is free");

  a_idle_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_i == (busy == '0))
    else $error("Idle flag %0d does not match running table %0h", idle_i, busy);

endmodule

bind issue_ctrl sequencer_chk i_sequencer_chk (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ready_i    (ara_req_ready_o),
  .pe_valid_i (pe_req_valid_o),
  .pe_id_i    (pe_req_o.id),
  .running_i  (running_q),
  .idle_i     (idle_o)
);

`default_nettype wire

// File: verif/tb_vector_sequencer.sv
`default_nettype none

module tb_vector_sequencer;
  import seq_pkg::*;

  // Clock cycles any single wait may take
  localparam int unsigned TIMEOUT = 16;

  // One row of the stimulus table
  typedef struct packed {
    vinsn_vec_t [NUM_UNITS-1:0] done;
    logic                       has_req;
    op_e                        op;
    vreg_t                      vd;
    vreg_t                      vs1;
    vreg_t                      vs2;
    logic                       accept;
    vid_t                       id;
    unit_e                      unit;
    vinsn_vec_t                 hz_vs1;
    vinsn_vec_t                 hz_vs2;
    vinsn_vec_t                 hz_vd;
  } step_t;

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  op_e                        req_op;
  vreg_t                      req_vd;
  vreg_t                      req_vs1;
  vreg_t                      req_vs2;
  logic                       req_ready;
  vinsn_vec_t [NUM_UNITS-1:0] unit_done;
  logic                       pe_valid;
  vid_t                       pe_id;
  op_e                        pe_op;
  unit_e                      pe_unit;
  vreg_t                      pe_vd;
  vreg_t                      pe_vs1;
  vreg_t                      pe_vs2;
  vinsn_vec_t                 pe_hz_vs1;
  vinsn_vec_t                 pe_hz_vs2;
  vinsn_vec_t                 pe_hz_vd;
  vinsn_vec_t [NUM_VINSN-1:0] hazard_table;
  logic                       idle;

  step_t steps[$];
  int    n_checks;
  int    n_errors;

  vector_sequencer DUT (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .ara_req_valid_i       (req_valid),
    .ara_req_op_i          (req_op),
    .ara_req_vd_i          (req_vd),
    .ara_req_vs1_i         (req_vs1),
    .ara_req_vs2_i         (req_vs2),
    .ara_req_ready_o       (req_ready),
    .unit_done_i           (unit_done),
    .pe_req_valid_o        (pe_valid),
    .pe_req_id_o           (pe_id),
    .pe_req_op_o           (pe_op),
    .pe_req_unit_o         (pe_unit),
    .pe_req_vd_o           (pe_vd),
    .pe_req_vs1_o          (pe_vs1),
    .pe_req_vs2_o          (pe_vs2),
    .pe_req_hazard_vs1_o   (pe_hz_vs1),
    .pe_req_hazard_vs2_o   (pe_hz_vs2),
    .pe_req_hazard_vd_o    (pe_hz_vd),
    .global_hazard_table_o (hazard_table),
    .idle_o                (idle)
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  task automatic add_step(input logic [31:0] done, input logic has_req, input op_e op,
                          input vreg_t vd, input vreg_t vs1, input vreg_t vs2,
                          input logic accept, input vid_t id, input unit_e unit,
                          input vinsn_vec_t hz_vs1, input vinsn_vec_t hz_vs2,
                          input vinsn_vec_t hz_vd);
    steps.push_back({done, has_req, op, vd, vs1, vs2, accept, id, unit,
                     hz_vs1, hz_vs2, hz_vd});
  endtask

  // Nothing running, nothing pending and nothing recorded in the table
  task automatic check_quiet_state(input string where);
    check_equal(32'(idle), 32'd1, {where, ": idle"});
    check_equal(32'(pe_valid), 32'd0, {where, ": PE request valid"});
    check_equal(32'(req_ready), 32'd1, {where, ": ready"});
    for (int i = 0; i < NUM_VINSN; i++) begin
      check_equal(32'(hazard_table[i]), 32'd0,
                  $sformatf("%s: hazard table row %0d", where, i));
    end
  endtask

  // Done rows are {STORE, LOAD, MUL, ALU}, one byte each
  task automatic build_table();
    // Independent instructions on three units
    add_step(32'h0000_0000, 1'b1, OP_VADD_VV, 5'd1, 5'd2, 5'd3,
             1'b1, 3'd0, UNIT_ALU, 8'h00, 8'h00, 8'h00);
    add_step(32'h0000_0000, 1'b1, OP_VMUL_VX, 5'd4, 5'd0, 5'd5,
             1'b1, 3'd1, UNIT_MUL, 8'h00, 8'h00, 8'h00);
    add_step(32'h0000_0000, 1'b1, OP_VSE, 5'd0, 5'd6, 5'd0,
             1'b1, 3'd2, UNIT_STORE, 8'h00, 8'h00, 8'h00);
    // RAW on v1 behind ID 0, then RAW on v4 and v1 plus WAR on v6 behind the store
    add_step(32'h0000_0000, 1'b1, OP_VADD_VV, 5'd7, 5'd1, 5'd8,
             1'b1, 3'd3, UNIT_ALU, 8'h01, 8'h00, 8'h00);
    add_step(32'h0000_0000, 1'b1, OP_VADD_VV, 5'd6, 5'd4, 5'd1,
             1'b1, 3'd4, UNIT_ALU, 8'h02, 8'h01, 8'h04);
    // The load queue holds two, so the third load waits for a done
    add_step(32'h0000_0000, 1'b1, OP_VLE, 5'd10, 5'd0, 5'd0,
             1'b1, 3'd5, UNIT_LOAD, 8'h00, 8'h00, 8'h00);
    add_step(32'h0000_0000, 1'b1, OP_VLE, 5'd11, 5'd0, 5'd0,
             1'b1, 3'd6, UNIT_LOAD, 8'h00, 8'h00, 8'h00);
    add_step(32'h0000_0000, 1'b1, OP_VLE, 5'd12, 5'd0, 5'd0,
             1'b0, 3'd0, UNIT_LOAD, 8'h00, 8'h00, 8'h00);
    add_step(32'h0020_0000, 1'b1, OP_VLE, 5'd12, 5'd0, 5'd0,
             1'b1, 3'd5, UNIT_LOAD, 8'h00, 8'h00, 8'h00);
    // Move without sources onto v7, still owned by ID 3
    add_step(32'h0000_0000, 1'b1, OP_VMV_VI, 5'd7, 5'd0, 5'd0,
             1'b0, 3'd0, UNIT_ALU, 8'h00, 8'h00, 8'h00);
    add_step(32'h0000_0008, 1'b1, OP_VMV_VI, 5'd7, 5'd0, 5'd0,
             1'b1, 3'd3, UNIT_ALU, 8'h00, 8'h00, 8'h00);
    // Fill the last ID, then a ninth instruction has to wait
    add_step(32'h0000_0000, 1'b1, OP_VMUL_VV, 5'd13, 5'd14, 5'd15,
             1'b1, 3'd7, UNIT_MUL, 8'h00, 8'h00, 8'h00);
    add_step(32'h0000_0000, 1'b1, OP_VMUL_VX, 5'd16, 5'd0, 5'd17,
             1'b0, 3'd0, UNIT_MUL, 8'h00, 8'h00, 8'h00);
    add_step(32'h0420_0201, 1'b1, OP_VMUL_VX, 5'd16, 5'd0, 5'd17,
             1'b1, 3'd0, UNIT_MUL, 8'h00, 8'h00, 8'h00);
    // Drain what is left
    add_step(32'h0040_0108, 1'b0, OP_VADD_VV, 5'd0, 5'd0, 5'd0,
             1'b0, 3'd0, UNIT_ALU, 8'h00, 8'h00, 8'h00);
    add_step(32'h0000_8010, 1'b0, OP_VADD_VV, 5'd0, 5'd0, 5'd0,
             1'b0, 3'd0, UNIT_ALU, 8'h00, 8'h00, 8'h00);
  endtask

  //////////////////////////////
  // One table step
  //////////////////////////////

  task automatic run_step(input int idx, input step_t s);
    int   cycles;
    int   errs_before;
    logic accepted;
    logic got_pulse;
    errs_before = n_errors;
    accepted    = 1'b0;
    got_pulse   = 1'b0;
    @(posedge clk);
    #1;
    unit_done = s.done;
    // Done strobes last one cycle, the request follows them
    if (s.done != '0) begin
      @(posedge clk);
      #1;
      unit_done = '0;
    end
    if (s.has_req) begin
      req_valid = 1'b1;
      req_op    = s.op;
      req_vd    = s.vd;
      req_vs1   = s.vs1;
      req_vs2   = s.vs2;
      cycles    = 0;
      // Ready is sampled mid cycle, the following rising edge accepts
      while (!accepted && cycles < TIMEOUT) begin
        @(negedge clk);
        accepted = req_ready;
        @(posedge clk);
        cycles++;
      end
      #1;
      req_valid = 1'b0;
      if (s.accept && !accepted) begin
        n_errors++;
        $display("Timeout at time %0t: step %0d was never accepted", $time, idx);
      end else if (!s.accept) begin
        check_equal(32'(accepted), 32'd0, "acceptance of a held request");
      end
      if (s.accept && accepted) begin
        cycles = 0;
        while (!got_pulse && cycles < TIMEOUT) begin
          @(negedge clk);
          cycles++;
          got_pulse = pe_valid;
        end
        if (!got_pulse) begin
          n_errors++;
          $display("Timeout at time %0t: step %0d gave no PE request", $time, idx);
        end else begin
          // The request register loads on the accepting edge, so the next falling edge sees it
          check_equal(32'(cycles), 32'd1, "falling edges until the PE request");
          check_equal(32'(pe_id), 32'(s.id), "PE request ID");
          check_equal(32'(pe_op), 32'(s.op), "PE request op");
          check_equal(32'(pe_unit), 32'(s.unit), "PE request unit");
          check_equal(32'(pe_vd), 32'(s.vd), "PE request vd");
          check_equal(32'(pe_vs1), 32'(s.vs1), "PE request vs1");
          check_equal(32'(pe_vs2), 32'(s.vs2), "PE request vs2");
          check_equal(32'(pe_hz_vs1), 32'(s.hz_vs1), "hazard_vs1");
          check_equal(32'(pe_hz_vs2), 32'(s.hz_vs2), "hazard_vs2");
          check_equal(32'(pe_hz_vd), 32'(s.hz_vd), "hazard_vd");
          check_equal(32'(hazard_table[s.id]), 32'(s.hz_vs1 | s.hz_vs2 | s.hz_vd),
                      "hazard table row of the new ID");
        end
      end
    end
    $display("step %0d: done=%08h accepted=%0d %s", idx, s.done, accepted,
             (n_errors == errs_before) ? "passed" : "failed");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    n_checks  = 0;
    n_errors  = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_op    = OP_VADD_VV;
    req_vd    = '0;
    req_vs1   = '0;
    req_vs2   = '0;
    unit_done = '0;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_quiet_state("after reset");
    for (int i = 0; i < steps.size(); i++) begin
      run_step(i, steps[i]);
    end
    // Hazard table columns clear one edge after the last done edge
    @(posedge clk);
    @(negedge clk);
    check_quiet_state("after drain");
    $display("%0d steps, %0d checks, %0d errors", steps.size(), n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/seq_pkg.sv
source/hazard_if.sv
source/op_decoder.sv
source/unit_queue_cnt.sv
source/hazard_tracker.sv
source/issue_ctrl.sv
source/vector_sequencer.sv
verif/sequencer_chk.sv
verif/tb_vector_sequencer.sv

// File: run.sh
#!/bin/sh
# Build the sequencer testbench with Verilator and run it into a log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_vector_sequencer \
  -f flist.f \
  -o tb_vector_sequencer

status=0
./obj_dir/tb_vector_sequencer > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
